// File: logic/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// clock cycles per serial bit
`define UART_CLKS_PER_BIT 16

// data bits in one frame
`define UART_DATA_BITS 8

// host command width in bits
`define UART_CMD_BITS 16

// start, data, parity and stop
`define UART_FRAME_BITS 11

`define UART_CMD_FRAMES 2

`endif

// File: logic/uart_pkg.sv
`include "uart_consts.svh"

package uart_pkg;

  // host command with the hi byte sent first
  typedef struct packed {
    logic [`UART_DATA_BITS-1:0] hi;
    logic [`UART_DATA_BITS-1:0] lo;
  } cmd_t;

  // one received frame with its error flags
  typedef struct packed {
    logic                       frame_err;
    logic                       parity_err;
    logic [`UART_DATA_BITS-1:0] data;
  } rx_result_t;

  // transmitter states
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  // receiver states
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

// File: logic/uart_baud_gen.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_baud_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic restart,
  input  logic run,
  output logic bit_tick,
  output logic mid_tick
);

  localparam int unsigned CNT_W = 2 * `UART_DATA_BITS;
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`UART_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] MID_CNT = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

  logic [CNT_W-1:0] cnt;

  // restart wins over run
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (restart) begin
      cnt <= '0;
    end else if (run) begin
      if (cnt == LAST_CNT) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // last cycle of the bit period
  assign bit_tick = run && (cnt == LAST_CNT);
  // halfway point for sampling
  assign mid_tick = run && (cnt == MID_CNT);

endmodule

// File: logic/uart_cmd_tx.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_cmd_tx (
  input  logic           clk,
  input  logic           rst_n,
  input  uart_pkg::cmd_t cmd_in,
  input  logic           cmd_vld,
  output logic           cmd_rdy,
  input  logic           bit_tick,
  output logic           baud_restart,
  output logic           baud_run,
  output logic           tx
);
  import uart_pkg::*;

  localparam logic [3:0] ALL_BITS = 4'(`UART_DATA_BITS);
  localparam logic [1:0] LAST_FRAME = 2'(`UART_CMD_FRAMES - 1);

  tx_state_e                  state;
  cmd_t                       cmd_q;
  logic [3:0]                 bit_cnt;
  logic [1:0]                 frame_cnt;
  logic [`UART_DATA_BITS-1:0] cur_byte;
  logic                       accept;

  assign cmd_rdy = (state == TX_IDLE);
  assign accept = cmd_vld && cmd_rdy;

  // bit period starts fresh with the start bit
  assign baud_restart = accept;
  assign baud_run = (state != TX_IDLE);

  // frame 0 carries hi
  assign cur_byte = (frame_cnt == 2'd0) ? cmd_q.hi : cmd_q.lo;

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= TX_IDLE;
      tx        <= 1'b1;
      bit_cnt   <= '0;
      frame_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (accept) begin
            state     <= TX_START;
            tx        <= 1'b0;
            frame_cnt <= '0;
          end
        end
        TX_START: begin
          if (bit_tick) begin
            state   <= TX_DATA;
            tx      <= cur_byte[0];
            bit_cnt <= 4'd1;
          end
        end
        TX_DATA: begin
          // bit_cnt holds the number of data bits already on the line
          if (bit_tick) begin
            if (bit_cnt == ALL_BITS) begin
              state <= TX_PARITY;
              tx    <= ~^cur_byte;
            end else begin
              tx      <= cur_byte[bit_cnt[2:0]];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        TX_PARITY: begin
          if (bit_tick) begin
            state <= TX_STOP;
            tx    <= 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_tick) begin
            if (frame_cnt == LAST_FRAME) begin
              state <= TX_IDLE;
              tx    <= 1'b1;
            end else begin
              // lo frame follows with no idle gap
              state     <= TX_START;
              tx        <= 1'b0;
              frame_cnt <= frame_cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= TX_IDLE;
          tx    <= 1'b1;
        end
      endcase
    end
  end

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_rx (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rx,
  input  logic                   mid_tick,
  output logic                   baud_restart,
  output logic                   baud_run,
  output uart_pkg::rx_result_t   read_data,
  output logic                   read_rdy
);
  import uart_pkg::*;

  localparam logic [3:0] LAST_BIT = 4'(`UART_DATA_BITS - 1);

  rx_state_e                  state;
  logic                       rx_meta;
  logic                       rx_sync;
  logic                       rx_prev;
  logic                       fall;
  logic [`UART_DATA_BITS-1:0] shreg;
  logic [3:0]                 bit_cnt;
  logic                       par_bit;
  rx_result_t                 result;

  // two flop synchronizer plus one for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // a line held low after a bad stop gives no edge, so idle waits for high
  assign fall = rx_prev && !rx_sync;

  assign baud_restart = (state == RX_IDLE) && fall;
  assign baud_run = (state != RX_IDLE);

  // ones over data and parity must be odd
  assign result.data = shreg;
  assign result.parity_err = ~^{shreg, par_bit};
  assign result.frame_err = !rx_sync;

  always_ff @(posedge clk) begin
    if (mid_tick) begin
      if (state == RX_DATA) begin
        shreg <= {rx_sync, shreg[`UART_DATA_BITS-1:1]};
      end
      if (state == RX_PARITY) begin
        par_bit <= rx_sync;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= RX_IDLE;
      bit_cnt   <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // glitch check at mid start
          if (mid_tick) begin
            if (rx_sync) begin
              state <= RX_IDLE;
            end else begin
              state   <= RX_DATA;
              bit_cnt <= '0;
            end
          end
        end
        RX_DATA: begin
          if (mid_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
              state <= RX_PARITY;
            end
          end
        end
        RX_PARITY: begin
          if (mid_tick) begin
            state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (mid_tick) begin
            state     <= RX_IDLE;
            read_data <= result;
            read_rdy  <= 1'b1;
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

endmodule

// File: logic/uart.sv
`timescale 1ns/1ns

module uart (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::cmd_t       cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output uart_pkg::rx_result_t read_data,
  output logic                 read_rdy
);

  logic tx_restart;
  logic tx_run;
  logic tx_bit_tick;
  logic rx_restart;
  logic rx_run;
  logic rx_mid_tick;

  uart_cmd_tx tx_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_in       (cmd_in),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .bit_tick     (tx_bit_tick),
    .baud_restart (tx_restart),
    .baud_run     (tx_run),
    .tx           (tx)
  );

  uart_baud_gen tx_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart  (tx_restart),
    .run      (tx_run),
    .bit_tick (tx_bit_tick),
    .mid_tick ()
  );

  uart_rx rx_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx           (rx),
    .mid_tick     (rx_mid_tick),
    .baud_restart (rx_restart),
    .baud_run     (rx_run),
    .read_data    (read_data),
    .read_rdy     (read_rdy)
  );

  // receiver samples on mid_tick only
  uart_baud_gen rx_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart  (rx_restart),
    .run      (rx_run),
    .bit_tick (),
    .mid_tick (rx_mid_tick)
  );

endmodule

// File: sim/uart_assertions.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_assertions (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy
);

  localparam int unsigned BUSY_CYCLES =
    `UART_CMD_FRAMES * `UART_FRAME_BITS * `UART_CLKS_PER_BIT;

  int unsigned fail_cnt = 0;
  int unsigned busy_cnt;

  // cycles spent with cmd_rdy low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_cnt <= 0;
    end else if (cmd_rdy) begin
      busy_cnt <= 0;
    end else begin
      busy_cnt <= busy_cnt + 1;
    end
  end

  // line rests high while idle
  idle_tx_high: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else begin
      fail_cnt++;
      $error("tx is low while cmd_rdy is high");
    end

  rdy_drops: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && cmd_rdy |=> !cmd_rdy)
    else begin
      fail_cnt++;
      $error("cmd_rdy stayed high after an accepted command");
    end

  // exactly two full frames
  busy_length: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> busy_cnt == BUSY_CYCLES)
    else begin
      fail_cnt++;
      $error("cmd_rdy was low for %0d cycles instead of %0d", busy_cnt, BUSY_CYCLES);
    end

  read_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else begin
      fail_cnt++;
      $error("read_rdy stayed high for more than one cycle");
    end

endmodule

bind uart uart_assertions chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

// File: sim/uart_tb.sv
`timescale 1ns/1ns
`include "uart_consts.svh"

module uart_tb;
  import uart_pkg::*;

  localparam int CLKS = `UART_CLKS_PER_BIT;
  // 20 tx frames, 12 rx frames with their idle gaps, one quiet frame
  localparam int TOTAL_FRAMES = 34;
  localparam int LIMIT = TOTAL_FRAMES * `UART_FRAME_BITS * CLKS * 12 / 10;

  logic       clk = 1'b0;
  logic       rst_n = 1'b0;
  cmd_t       cmd_in = '0;
  logic       cmd_vld = 1'b0;
  logic       rx = 1'b1;
  logic       cmd_rdy;
  logic       tx;
  rx_result_t read_data;
  logic       read_rdy;

  logic [15:0] lfsr = 16'd77;
  int          errors = 0;
  int          tests = 0;
  int          failed = 0;
  int          cycles = 0;

  uart uart_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, the DUT never finished a transfer", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // 16-bit Fibonacci with taps 16 14 13 11
  function automatic logic [15:0] rand_bits(input int n);
    logic        fb;
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val = {val[14:0], fb};
    end
    return val;
  endfunction

  function automatic int err_total();
    return errors + int'(uart_i.chk_i.fail_cnt);
  endfunction

  task automatic expect_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (err_total() != errs_before) begin
      failed++;
    end
    $display("test %0d %s: %s", tests, name, (err_total() == errs_before) ? "ok" : "failed");
  endtask

  // finds a start bit on tx, then samples every bit at its middle
  task automatic capture_frame(output logic [7:0] data);
    logic [10:0] bits;
    do begin
      @(negedge clk);
    end while (tx);
    repeat (CLKS / 2 - 1) @(negedge clk);
    for (int i = 0; i < `UART_FRAME_BITS; i++) begin
      if (i > 0) begin
        repeat (CLKS) @(negedge clk);
      end
      bits[i] = tx;
    end
    data = bits[8:1];
    expect_eq(bits[0], 1'b0, "tx start bit");
    expect_eq(^bits[9:1], 1'b1, "tx odd parity");
    expect_eq(bits[10], 1'b1, "tx stop bit");
  endtask

  task automatic check_cmd(input cmd_t c);
    logic [7:0] hi;
    logic [7:0] lo;
    while (!cmd_rdy) @(negedge clk);
    fork
      begin
        cmd_in = c;
        cmd_vld = 1'b1;
        @(negedge clk);
        cmd_vld = 1'b0;
      end
      begin
        capture_frame(hi);
        capture_frame(lo);
      end
    join
    expect_eq(hi, c.hi, "tx hi byte");
    expect_eq(lo, c.lo, "tx lo byte");
  endtask

  // start, data LSB first, parity, stop, then one idle bit
  task automatic drive_frame(input logic [7:0] data, input logic bad_par, input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, (~^data) ^ bad_par, data, 1'b0};
    for (int i = 0; i < `UART_FRAME_BITS; i++) begin
      rx = bits[i];
      repeat (CLKS) @(negedge clk);
    end
    rx = 1'b1;
    repeat (CLKS) @(negedge clk);
  endtask

  task automatic check_rx(input logic [7:0] data, input logic bad_par, input logic bad_stop);
    rx_result_t got;
    logic       seen;
    int         waited;
    waited = 0;
    fork
      drive_frame(data, bad_par, bad_stop);
      begin
        while (!read_rdy && waited < 12 * CLKS) begin
          @(negedge clk);
          waited++;
        end
        seen = read_rdy;
        got = read_data;
      end
    join
    assert (seen) else begin
      $display("read_rdy never pulsed for rx byte %h", data);
      errors++;
    end
    expect_eq(got.data, data, "rx data");
    expect_eq(got.parity_err, bad_par, "rx parity_err");
    expect_eq(got.frame_err, bad_stop, "rx frame_err");
  endtask

  initial begin
    logic [15:0] r;
    logic [15:0] r2;
    int          e0;
    int          extra;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    e0 = err_total();
    expect_eq(tx, 1'b1, "tx after reset");
    expect_eq(cmd_rdy, 1'b1, "cmd_rdy after reset");
    expect_eq(read_rdy, 1'b0, "read_rdy after reset");
    expect_eq(read_data, '0, "read_data after reset");
    end_test("reset values", e0);

    e0 = err_total();
    for (int i = 0; i < 8; i++) begin
      r = rand_bits(`UART_CMD_BITS);
      check_cmd(r);
    end
    end_test("random commands on tx", e0);

    // second strobe lands in the middle of the hi frame
    e0 = err_total();
    r = rand_bits(`UART_CMD_BITS);
    fork
      check_cmd(r);
      begin
        repeat (4 * CLKS) @(negedge clk);
        cmd_in = ~r;
        cmd_vld = 1'b1;
        @(negedge clk);
        cmd_vld = 1'b0;
      end
    join
    extra = 0;
    repeat (`UART_FRAME_BITS * CLKS) begin
      @(negedge clk);
      if (tx !== 1'b1) begin
        extra++;
      end
    end
    expect_eq(16'(extra), 16'd0, "tx low cycles after ignored strobe");
    end_test("strobe while busy", e0);

    e0 = err_total();
    for (int i = 0; i < 8; i++) begin
      r = rand_bits(`UART_DATA_BITS);
      check_rx(r[7:0], 1'b0, 1'b0);
    end
    end_test("random bytes on rx", e0);

    e0 = err_total();
    r = rand_bits(`UART_DATA_BITS);
    check_rx(r[7:0], 1'b1, 1'b0);
    r = rand_bits(`UART_DATA_BITS);
    check_rx(r[7:0], 1'b0, 1'b1);
    r = rand_bits(`UART_DATA_BITS);
    check_rx(r[7:0], 1'b0, 1'b0);
    end_test("rx parity and framing errors", e0);

    e0 = err_total();
    r = rand_bits(`UART_CMD_BITS);
    r2 = rand_bits(`UART_DATA_BITS);
    fork
      check_cmd(r);
      check_rx(r2[7:0], 1'b0, 1'b0);
    join
    end_test("tx and rx together", e0);

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests, failed, errors, uart_i.chk_i.fail_cnt);
    if (err_total() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_cmd_tx.sv
logic/uart_rx.sv
logic/uart.sv
sim/uart_assertions.sv
sim/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f sim.f -o uart_sim &&
./obj_dir/uart_sim +verilator+error+limit+100 | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run_sim: OK" ||
{ echo "run_sim: FAILURE"; exit 1; }
